// File: design/bp.sv
/* static branch predictor: JAL taken, backward branch taken, else pc + 4 */

`timescale 1ns/1ps
`include "mem_front_params.svh"

module bp (
    input  mem_front_pkg::inst_u inst,
    input  logic [`ADDR_W-1:0]   pc,
    output logic                 pred_taken,
    output logic [`ADDR_W-1:0]   pred_target
);
    import mem_front_pkg::*;

    logic               is_jal;
    logic               is_branch;
    logic [`ADDR_W-1:0] b_off;
    logic [`ADDR_W-1:0] j_off;
    logic [`ADDR_W-1:0] offset;

    assign is_jal    = (inst.j_fmt.opcode == OPC_JAL);
    assign is_branch = (inst.b_fmt.opcode == OPC_BRANCH);

    // B-type offset, 13 bits signed
    assign b_off = {
        {(`ADDR_W - 13){inst.b_fmt.imm12}},
        inst.b_fmt.imm12,
        inst.b_fmt.imm11,
        inst.b_fmt.imm10_5,
        inst.b_fmt.imm4_1,
        1'b0
    };

    // J-type offset, 21 bits signed
    assign j_off = {
        {(`ADDR_W - 21){inst.j_fmt.imm20}},
        inst.j_fmt.imm20,
        inst.j_fmt.imm19_12,
        inst.j_fmt.imm11,
        inst.j_fmt.imm10_1,
        1'b0
    };

    assign offset = is_jal ? j_off : b_off;

    // sign bit set means a backward branch
    assign pred_taken = is_jal || (is_branch && inst.b_fmt.imm12);

    always_comb begin
        if (pred_taken) begin
            pred_target = pc + offset;
        end else begin
            pred_target = pc + `ADDR_W'(4);
        end
    end

endmodule

// File: design/fetcher.sv
/* program counter, fetch requests, two-entry instruction queue, redirect flush */

`timescale 1ns/1ps
`include "mem_front_params.svh"

module fetcher (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  logic                 rdy_in,
    input  logic                 redirect_en,
    input  logic [`ADDR_W-1:0]   redirect_pc,
    output logic                 fetch_en,
    output logic [`ADDR_W-1:0]   fetch_addr,
    input  logic                 fetch_done,
    input  logic [`DATA_W-1:0]   fetch_word,
    output mem_front_pkg::inst_u bp_inst,
    output logic [`ADDR_W-1:0]   bp_pc,
    input  logic                 pred_taken,
    input  logic [`ADDR_W-1:0]   pred_target,
    input  logic                 decode_full,
    output logic                 inst_valid,
    output mem_front_pkg::inst_u inst,
    output logic [`ADDR_W-1:0]   inst_pc,
    output logic                 inst_pred
);
    import mem_front_pkg::*;

    localparam int ptr_w = $clog2(`IQ_DEPTH);

    logic [`ADDR_W-1:0] pc;
    logic               discard;
    logic [ptr_w-1:0]   head;
    logic [ptr_w-1:0]   tail;
    logic [ptr_w:0]     count;
    inst_u              q_inst [`IQ_DEPTH];
    logic [`ADDR_W-1:0] q_pc   [`IQ_DEPTH];
    logic               q_pred [`IQ_DEPTH];
    logic               push;
    logic               pop;
    logic               room;
    logic               issue;

    // predictor sees the returning word and its address
    assign bp_inst = fetch_word;
    assign bp_pc   = fetch_addr;

    assign push  = fetch_done && !discard && !redirect_en;
    assign pop   = inst_valid && !decode_full;
    assign room  = (count != (ptr_w + 1)'(`IQ_DEPTH));
    assign issue = !fetch_en && room && !redirect_en;

    assign inst_valid = (count != '0) && !redirect_en;
    assign inst       = q_inst[head];
    assign inst_pc    = q_pc[head];
    assign inst_pred  = q_pred[head];

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            pc       <= '0;
            fetch_en <= 1'b0;
            discard  <= 1'b0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else if (rdy_in) begin
            if (fetch_done) begin
                fetch_en <= 1'b0;
                discard  <= 1'b0;
            end else if (redirect_en && fetch_en) begin
                // old fetch still completes on the bus
                discard <= 1'b1;
            end else if (issue) begin
                fetch_en <= 1'b1;
            end

            if (redirect_en) begin
                pc    <= redirect_pc;
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (push) begin
                    pc   <= pred_target;
                    tail <= tail + 1'b1;
                end
                if (pop) begin
                    head <= head + 1'b1;
                end
                if (push && !pop) begin
                    count <= count + 1'b1;
                end else if (pop && !push) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (issue) begin
                fetch_addr <= pc;
            end
            if (push) begin
                q_inst[tail] <= fetch_word;
                q_pc[tail]   <= fetch_addr;
                q_pred[tail] <= pred_taken;
            end
        end
    end

    // a new entry is visible only after a real push
    a_valid_needs_entry: assert property (@(posedge clk_in) disable iff (!rst_n)
        $rose(inst_valid) |-> ($past(count) != '0) || $past(push && rdy_in));

endmodule

// File: design/mem_front.sv
/* memory-side front end: fetcher, branch predictor and byte-serial memctrl */

`timescale 1ns/1ps
`include "mem_front_params.svh"

module mem_front (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  logic                    rdy_in,
    input  logic [7:0]              mem_din,
    output logic [7:0]              mem_dout,
    output logic [`ADDR_W-1:0]      mem_a,
    output logic                    mem_wr,
    input  logic                    io_buffer_full,
    input  logic                    redirect_en,
    input  logic [`ADDR_W-1:0]      redirect_pc,
    input  logic                    decode_full,
    output logic                    inst_valid,
    output mem_front_pkg::inst_u    inst,
    output logic [`ADDR_W-1:0]      inst_pc,
    output logic                    inst_pred,
    input  logic                    lsu_en,
    input  logic                    lsu_store,
    input  mem_front_pkg::acc_len_t lsu_len,
    input  logic [`ADDR_W-1:0]      lsu_addr,
    input  logic [`DATA_W-1:0]      lsu_wdata,
    output logic                    lsu_done,
    output logic [`DATA_W-1:0]      lsu_rdata
);
    import mem_front_pkg::*;

    // fetcher to memctrl
    logic               fetch_en;
    logic [`ADDR_W-1:0] fetch_addr;
    logic               fetch_done;
    logic [`DATA_W-1:0] fetch_word;

    // fetcher to predictor
    inst_u              bp_inst;
    logic [`ADDR_W-1:0] bp_pc;
    logic               pred_taken;
    logic [`ADDR_W-1:0] pred_target;

    fetcher fetcher (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .rdy_in      (rdy_in),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_word  (fetch_word),
        .bp_inst     (bp_inst),
        .bp_pc       (bp_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .decode_full (decode_full),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_pred   (inst_pred)
    );

    bp bp (
        .inst        (bp_inst),
        .pc          (bp_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    memctrl memctrl (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .fetch_en       (fetch_en),
        .fetch_addr     (fetch_addr),
        .fetch_done     (fetch_done),
        .fetch_word     (fetch_word),
        .lsu_en         (lsu_en),
        .lsu_store      (lsu_store),
        .lsu_len        (lsu_len),
        .lsu_addr       (lsu_addr),
        .lsu_wdata      (lsu_wdata),
        .lsu_done       (lsu_done),
        .lsu_rdata      (lsu_rdata)
    );

endmodule

// File: design/mem_front_params.svh
/* bus widths, RAM and I/O address map, and instruction queue depth */

`ifndef MEM_FRONT_PARAMS_SVH
`define MEM_FRONT_PARAMS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32

// top of RAM, 128 KB of byte storage
`define MEM_LIMIT 32'h0002_0000

// I/O space starts here, decoded from address bits 17:16
`define IO_BASE 32'h0003_0000

// entries between fetch and decode
`define IQ_DEPTH 2

`endif

// File: design/mem_front_pkg.sv
/* instruction word union, access length type and RV32I opcode constants */

package mem_front_pkg;

    // B-type fields, immediate scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type fields
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, seen three ways
    typedef union packed {
        logic [31:0] raw;
        b_fmt_t      b_fmt;
        j_fmt_t      j_fmt;
    } inst_u;

    // access length of a data request
    typedef logic [1:0] acc_len_t;

    localparam acc_len_t LEN_BYTE = 2'd0;
    localparam acc_len_t LEN_HALF = 2'd1;
    localparam acc_len_t LEN_WORD = 2'd2;

    // control transfer opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

// File: design/memctrl.sv
/* byte-serial memory controller, fetch and data port arbitration,
   I/O write stall on a full output buffer */

`timescale 1ns/1ps
`include "mem_front_params.svh"

module memctrl (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  logic                    rdy_in,
    input  logic                    io_buffer_full,
    input  logic [7:0]              mem_din,
    output logic [7:0]              mem_dout,
    output logic [`ADDR_W-1:0]      mem_a,
    output logic                    mem_wr,
    input  logic                    fetch_en,
    input  logic [`ADDR_W-1:0]      fetch_addr,
    output logic                    fetch_done,
    output logic [`DATA_W-1:0]      fetch_word,
    input  logic                    lsu_en,
    input  logic                    lsu_store,
    input  mem_front_pkg::acc_len_t lsu_len,
    input  logic [`ADDR_W-1:0]      lsu_addr,
    input  logic [`DATA_W-1:0]      lsu_wdata,
    output logic                    lsu_done,
    output logic [`DATA_W-1:0]      lsu_rdata
);
    import mem_front_pkg::*;

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_read  = 2'd1;
    localparam logic [1:0] st_write = 2'd2;
    localparam logic [`ADDR_W-1:0] io_base = `IO_BASE;

    logic [1:0]         state;
    logic [1:0]         cnt;
    logic [1:0]         last_idx;
    logic [1:0]         lsu_last;
    logic               owner_fetch;
    logic [`ADDR_W-1:0] cur_addr;
    logic [`ADDR_W-1:0] a_next;
    logic [`ADDR_W-1:0] a_hold;
    logic [`DATA_W-1:0] wbuf;
    logic [`DATA_W-1:0] asm_word;
    logic [`DATA_W-1:0] asm_next;
    logic [`DATA_W-1:0] rd_word;
    logic               req_lsu;
    logic               req_fetch;
    logic               io_stall;
    logic               addr_left;
    logic               last_byte;

    // index of the final byte for each access length
    always_comb begin
        case (lsu_len)
            LEN_BYTE: lsu_last = 2'd0;
            LEN_HALF: lsu_last = 2'd1;
            default:  lsu_last = 2'd3;
        endcase
    end

    // a requester still holds en during its done cycle
    assign req_lsu   = lsu_en && !lsu_done;
    assign req_fetch = fetch_en && !fetch_done;

    assign io_stall  = (cur_addr[17:16] == io_base[17:16]) && io_buffer_full;
    assign addr_left = (cnt != last_idx);
    assign last_byte = (cnt == last_idx);
    assign asm_next  = {mem_din, asm_word[`DATA_W-1:8]};

    // bus drive, byte 0 of a read goes out in the accepting cycle
    always_comb begin
        a_next   = '0;
        mem_dout = 8'h00;
        mem_wr   = 1'b0;
        case (state)
            st_idle: begin
                if (req_lsu) begin
                    if (!lsu_store) begin
                        a_next = lsu_addr;
                    end
                end else if (req_fetch) begin
                    a_next = fetch_addr;
                end
            end
            st_read: begin
                if (addr_left) begin
                    a_next = cur_addr;
                end
            end
            st_write: begin
                a_next   = cur_addr;
                mem_dout = wbuf[7:0];
                mem_wr   = rdy_in && !io_stall;
            end
            default: begin
                a_next = '0;
            end
        endcase
    end

    // keep the last issued address while paused so mem_din stays in step
    assign mem_a = rdy_in ? a_next : a_hold;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state       <= st_idle;
            cnt         <= 2'd0;
            last_idx    <= 2'd0;
            owner_fetch <= 1'b0;
            fetch_done  <= 1'b0;
            lsu_done    <= 1'b0;
            a_hold      <= '0;
        end else if (rdy_in) begin
            fetch_done <= 1'b0;
            lsu_done   <= 1'b0;
            a_hold     <= a_next;
            case (state)
                st_idle: begin
                    cnt <= 2'd0;
                    // data side first
                    if (req_lsu) begin
                        owner_fetch <= 1'b0;
                        last_idx    <= lsu_last;
                        state       <= lsu_store ? st_write : st_read;
                    end else if (req_fetch) begin
                        owner_fetch <= 1'b1;
                        last_idx    <= 2'd3;
                        state       <= st_read;
                    end
                end
                st_read: begin
                    cnt <= cnt + 2'd1;
                    if (last_byte) begin
                        state      <= st_idle;
                        fetch_done <= owner_fetch;
                        lsu_done   <= !owner_fetch;
                    end
                end
                st_write: begin
                    if (!io_stall) begin
                        cnt <= cnt + 2'd1;
                        if (last_byte) begin
                            state    <= st_idle;
                            lsu_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address, write buffer and read assembly
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            case (state)
                st_idle: begin
                    if (req_lsu) begin
                        cur_addr <= lsu_store ? lsu_addr : lsu_addr + `ADDR_W'(1);
                        wbuf     <= lsu_wdata;
                    end else if (req_fetch) begin
                        cur_addr <= fetch_addr + `ADDR_W'(1);
                    end
                end
                st_read: begin
                    asm_word <= asm_next;
                    if (addr_left) begin
                        cur_addr <= cur_addr + `ADDR_W'(1);
                    end
                    // right-align the bytes, upper part zero filled
                    if (last_byte) begin
                        rd_word <= asm_next >> {~last_idx, 3'b000};
                    end
                end
                st_write: begin
                    if (!io_stall) begin
                        cur_addr <= cur_addr + `ADDR_W'(1);
                        wbuf     <= wbuf >> 8;
                    end
                end
                default: begin
                    rd_word <= rd_word;
                end
            endcase
        end
    end

    assign fetch_word = rd_word;
    assign lsu_rdata  = rd_word;

    // one owner per transaction
    a_single_done: assert property (@(posedge clk_in) disable iff (!rst_n)
        !(fetch_done && lsu_done));

    // no byte reaches the UART while its buffer is full
    a_io_no_overrun: assert property (@(posedge clk_in) disable iff (!rst_n)
        (mem_wr && mem_a[17:16] == io_base[17:16]) |-> !io_buffer_full);

endmodule

// File: mem_front.f
+incdir+design
design/mem_front_pkg.sv
design/memctrl.sv
design/fetcher.sv
design/bp.sv
design/mem_front.sv
tests/tb_mem_model.sv
tests/tb_mem_front.sv

// File: tests/tb_mem_front.sv
/* testbench for mem_front: program image, redirects, data port, I/O stall,
   rdy_in pauses, reference pc model and concurrent checks */

`timescale 1ns/1ps
`include "mem_front_params.svh"

module tb_mem_front;
    import mem_front_pkg::*;

    localparam int max_cycles = 4000;

    logic                    clk_in = 1'b0;
    logic                    rst_n = 1'b0;
    logic                    rdy_in = 1'b1;
    logic [7:0]              mem_din;
    logic [7:0]              mem_dout;
    logic [`ADDR_W-1:0]      mem_a;
    logic                    mem_wr;
    logic                    io_buffer_full;
    logic                    redirect_en = 1'b0;
    logic [`ADDR_W-1:0]      redirect_pc = '0;
    logic                    decode_full = 1'b0;
    logic                    inst_valid;
    inst_u                   inst;
    logic [`ADDR_W-1:0]      inst_pc;
    logic                    inst_pred;
    logic                    lsu_en = 1'b0;
    logic                    lsu_store = 1'b0;
    acc_len_t                lsu_len = LEN_BYTE;
    logic [`ADDR_W-1:0]      lsu_addr = '0;
    logic [`DATA_W-1:0]      lsu_wdata = '0;
    logic                    lsu_done;
    logic [`DATA_W-1:0]      lsu_rdata;

    logic [31:0]             prog [0:7];
    logic [7:0]              shadow [logic [31:0]];
    logic [`ADDR_W-1:0]      exp_pc;
    logic [`DATA_W-1:0]      exp_rdata = '0;
    logic                    chk_load = 1'b0;
    logic                    accept;
    int                      cycles = 0;
    int                      n_accept = 0;
    int                      n_loads = 0;
    int                      n_io = 0;

    always #20 clk_in = ~clk_in;

    mem_front dut (.*);

    tb_mem_model mem_model (
        .clk_in         (clk_in),
        .mem_a          (mem_a),
        .mem_dout       (mem_dout),
        .mem_wr         (mem_wr),
        .mem_din        (mem_din),
        .io_buffer_full (io_buffer_full)
    );

    function automatic logic [31:0] enc_b(input int off, input logic [2:0] f3);
        logic [12:0] i;
        i = 13'(off);
        return {i[12], i[10:5], 5'd0, 5'd0, f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input int off);
        logic [20:0] i;
        i = 21'(off);
        return {i[20], i[10:1], i[11], i[19:12], 5'd0, 7'b1101111};
    endfunction

    // RV32I static rule: JAL taken, branch taken only when offset is negative
    function automatic logic pred_bit(input logic [31:0] w);
        return (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100011 && w[31]);
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] w, input logic [31:0] pc);
        logic [31:0] boff;
        logic [31:0] joff;
        boff = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        joff = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        if (w[6:0] == 7'b1101111) begin
            return pc + joff;
        end else if (w[6:0] == 7'b1100011 && w[31]) begin
            return pc + boff;
        end
        return pc + 32'd4;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
        $display("[FAIL] %s expected %h actual %h", name, expv, actv);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    assign accept = rdy_in && inst_valid && !decode_full;

    // reference pc, follows redirects and the static rule
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            exp_pc <= '0;
        end else if (rdy_in) begin
            if (redirect_en) begin
                exp_pc <= redirect_pc;
            end else if (accept) begin
                exp_pc   <= next_pc(prog[exp_pc[4:2]], exp_pc);
                n_accept <= n_accept + 1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (rst_n && rdy_in && lsu_done && chk_load) begin
            n_loads <= n_loads + 1;
        end
        if (mem_wr && mem_a[17:16] == 2'b11) begin
            n_io <= n_io + 1;
        end
        if (cycles == max_cycles) begin
            fail_text("timeout: run exceeded its cycle limit");
        end
    end

    a_inst_pc: assert property (@(posedge clk_in) disable iff (!rst_n)
        accept |-> inst_pc == exp_pc)
        else fail_value("inst_pc", $sampled(exp_pc), $sampled(inst_pc));

    a_inst_word: assert property (@(posedge clk_in) disable iff (!rst_n)
        accept |-> inst == prog[exp_pc[4:2]])
        else fail_value("inst_word", $sampled(prog[exp_pc[4:2]]), $sampled(inst));

    a_inst_pred: assert property (@(posedge clk_in) disable iff (!rst_n)
        accept |-> inst_pred == pred_bit(prog[exp_pc[4:2]]))
        else fail_value("inst_pred", 32'(pred_bit($sampled(prog[exp_pc[4:2]]))),
                        32'($sampled(inst_pred)));

    a_load_data: assert property (@(posedge clk_in) disable iff (!rst_n)
        (lsu_done && chk_load) |-> lsu_rdata == exp_rdata)
        else fail_value("load_data", $sampled(exp_rdata), $sampled(lsu_rdata));

    a_done_owner: assert property (@(posedge clk_in) disable iff (!rst_n)
        lsu_done |-> lsu_en)
        else fail_text("lsu_done pulsed with no data request pending");

    a_io_stall: assert property (@(posedge clk_in) disable iff (!rst_n)
        (mem_wr && mem_a[17:16] == 2'b11) |-> !io_buffer_full)
        else fail_text("I/O byte written while the output buffer was full");

    a_rdy_no_wr: assert property (@(posedge clk_in) disable iff (!rst_n)
        !rdy_in |-> !mem_wr)
        else fail_text("mem_wr driven while rdy_in was low");

    a_rdy_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
        (!rdy_in && $past(!rdy_in)) |->
            ($stable(mem_a) && $stable(inst_valid) && $stable(inst_pc)))
        else fail_text("mem_a, inst_valid or inst_pc changed while rdy_in was low");

    task automatic lsu_access(input logic store, input acc_len_t len,
                              input logic [31:0] addr, input logic [31:0] wdata);
        int          n;
        logic [31:0] expv;
        n = (len == LEN_BYTE) ? 1 : (len == LEN_HALF) ? 2 : 4;
        expv = '0;
        for (int k = 0; k < n; k++) begin
            if (store) begin
                shadow[addr + k] = wdata[8*k +: 8];
            end else begin
                expv[8*k +: 8] = shadow[addr + k];
            end
        end
        @(posedge clk_in);
        lsu_en    <= 1'b1;
        lsu_store <= store;
        lsu_len   <= len;
        lsu_addr  <= addr;
        lsu_wdata <= wdata;
        exp_rdata <= expv;
        chk_load  <= !store;
        // done only counts once the DUT clears it
        do begin
            @(posedge clk_in);
        end while (!(lsu_done === 1'b1 && rdy_in === 1'b1));
        lsu_en   <= 1'b0;
        chk_load <= 1'b0;
    endtask

    task automatic run_fetch(input int n, input logic with_redirect);
        logic [31:0] targets [5];
        targets = '{32'd0, 32'd4, 32'd12, 32'd24, 32'd28};
        repeat (n) begin
            @(posedge clk_in);
            decode_full <= ($urandom % 4 == 0);
            if (with_redirect && !redirect_en && $urandom % 40 == 0) begin
                redirect_en <= 1'b1;
                redirect_pc <= targets[$urandom % 5];
            end else begin
                redirect_en <= 1'b0;
            end
        end
        @(posedge clk_in);
        redirect_en <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h8c0d7947));
        prog[0] = 32'h00100093;
        prog[1] = enc_b(8, 3'b000);
        prog[2] = enc_j(16);
        prog[3] = 32'h00208113;
        prog[4] = enc_b(12, 3'b001);
        prog[5] = 32'h00310193;
        prog[6] = 32'h00000013;
        prog[7] = enc_b(-28, 3'b001);
        @(posedge clk_in);
        // program image, little endian
        for (int w = 0; w < 8; w++) begin
            for (int k = 0; k < 4; k++) begin
                mem_model.ram[4*w + k] = prog[w][8*k +: 8];
            end
        end
        repeat (15) @(posedge clk_in);
        rst_n <= 1'b1;

        run_fetch(300, 1'b0);
        run_fetch(400, 1'b1);

        // data port while fetches keep running
        fork
            run_fetch(250, 1'b0);
            begin
                lsu_access(1'b1, LEN_WORD, 32'h1000, $urandom);
                lsu_access(1'b1, LEN_HALF, 32'h1004, $urandom);
                lsu_access(1'b1, LEN_BYTE, 32'h1006, $urandom);
                lsu_access(1'b1, LEN_BYTE, 32'h1007, $urandom);
                lsu_access(1'b0, LEN_WORD, 32'h1000, '0);
                lsu_access(1'b0, LEN_HALF, 32'h1004, '0);
                lsu_access(1'b0, LEN_BYTE, 32'h1006, '0);
                lsu_access(1'b0, LEN_WORD, 32'h1004, '0);
                lsu_access(1'b0, LEN_BYTE, 32'h1001, '0);
                lsu_access(1'b0, LEN_HALF, 32'h1002, '0);
            end
        join

        // UART writes, some start inside a buffer-full window
        for (int i = 0; i < 4; i++) begin
            if (i == 0) begin
                // first write lands just after a full window opens
                while (io_buffer_full !== 1'b0) begin
                    @(posedge clk_in);
                end
                while (io_buffer_full !== 1'b1) begin
                    @(posedge clk_in);
                end
            end else begin
                repeat ($urandom % 30) @(posedge clk_in);
            end
            lsu_access(1'b1, LEN_BYTE, `IO_BASE, $urandom);
        end

        // random pauses across fetches, stores and loads
        fork
            begin
                repeat (200) begin
                    @(posedge clk_in);
                    rdy_in      <= ($urandom % 3 != 0);
                    decode_full <= ($urandom % 4 == 0);
                end
                @(posedge clk_in);
                rdy_in <= 1'b1;
            end
            begin
                lsu_access(1'b1, LEN_WORD, 32'h1010, $urandom);
                lsu_access(1'b1, LEN_BYTE, `IO_BASE, $urandom);
                lsu_access(1'b0, LEN_WORD, 32'h1010, '0);
                lsu_access(1'b0, LEN_HALF, 32'h1012, '0);
            end
        join
        run_fetch(100, 1'b1);
        repeat (10) @(posedge clk_in);

        if (n_accept < 50 || n_loads < 8 || n_io < 5) begin
            $display("too few instructions, loads or I/O writes were completed");
            $display("Checks failed");
            $fatal(1);
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: tests/tb_mem_model.sv
/* 128 KB byte RAM with one-cycle read latency, I/O writes ignored,
   periodic output buffer-full pattern */

`timescale 1ns/1ps
`include "mem_front_params.svh"

module tb_mem_model (
    input  logic               clk_in,
    input  logic [`ADDR_W-1:0] mem_a,
    input  logic [7:0]         mem_dout,
    input  logic               mem_wr,
    output logic [7:0]         mem_din,
    output logic               io_buffer_full
);
    localparam logic [`ADDR_W-1:0] mem_limit = `MEM_LIMIT;

    logic [7:0] ram [0:`MEM_LIMIT-1];
    logic [5:0] io_cnt = 6'd0;
    logic       in_ram;

    initial begin
        logic [16:0] a;
        mem_din = 8'h00;
        // every address bit reaches the fill byte
        for (int i = 0; i < `MEM_LIMIT; i++) begin
            a = 17'(i);
            ram[i] = a[7:0] ^ a[15:8] ^ {a[16], 7'h2b};
        end
    end

    assign in_ram = (mem_a < mem_limit);

    always @(posedge clk_in) begin
        if (mem_wr && in_ram) begin
            ram[mem_a[16:0]] <= mem_dout;
        end
        mem_din <= in_ram ? ram[mem_a[16:0]] : 8'h00;
    end

    // buffer full for 20 of every 64 cycles
    always_ff @(posedge clk_in) begin
        io_cnt <= io_cnt + 6'd1;
    end

    assign io_buffer_full = (io_cnt < 6'd20);

endmodule
